/* project.f */
hw/zynq_shell_pkg.sv
hw/host_csr.sv
hw/host_window_xlate.sv
hw/dram_rebase.sv
hw/perf_counters.sv
hw/zynq_host_shell.sv
test/zynq_host_shell_assert.sv
test/zynq_host_shell_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --assert -f project.f --top-module zynq_host_shell_tb; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vzynq_host_shell_tb +verilator+error+limit+1000 > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -qx "test passed" sim.log; then
   exit 0
fi
exit 1

/* test/zynq_host_shell_tb.sv */
`default_nettype none

module zynq_host_shell_tb
   import zynq_shell_pkg::*;
();

   localparam int clk_period    = 10;
   localparam int win_items     = 80;
   localparam int dram_items    = 80;
   localparam int retire_cycles = 64;
   // a stream item needs about four cycles under random stalls and gaps
   localparam int test_cycles   = 80 + 4 * win_items + 4 * dram_items + 120 + retire_cycles + 60;
   localparam int cycle_limit   = 2 * test_cycles;

   logic                       aclk_i = 1'b0;
   logic                       rst_n_i;
   logic                       csr_wr_valid_i;
   logic                       csr_wr_ready_o;
   logic [csr_addr_width-1:0]  csr_wr_addr_i;
   logic [reg_width-1:0]       csr_wr_data_i;
   logic                       csr_rd_valid_i;
   logic                       csr_rd_ready_o;
   logic [csr_addr_width-1:0]  csr_rd_addr_i;
   logic                       csr_rdata_valid_o;
   logic                       csr_rdata_ready_i;
   logic [reg_width-1:0]       csr_rdata_o;
   logic                       win_valid_i;
   logic                       win_ready_o;
   logic [host_addr_width-1:0] win_addr_i;
   logic                       core_win_valid_o;
   logic                       core_win_ready_i;
   logic [core_addr_width-1:0] core_win_addr_o;
   logic                       dram_req_valid_i;
   logic                       dram_req_ready_o;
   logic [core_addr_width-1:0] dram_req_addr_i;
   logic                       mem_valid_o;
   logic                       mem_ready_i;
   logic [core_addr_width-1:0] mem_addr_o;
   logic                       retire_i;
   logic                       dram_range_err_o;
   logic                       core_reset_o;
   logic                       dram_alloc_o;

   logic [31:0]               lfsr_state = 32'h7183_a008;
   int                        cycles = 0;
   int                        checks = 0;
   int                        errors = 0;
   int                        test_errors = 0;
   logic [31:0]               exp_q[$];
   logic [region_count-1:0]   hits_model;
   logic                      range_model;
   logic [31:0]               base_model;

   zynq_host_shell dut (.*);

   always #(clk_period / 2) aclk_i = ~aclk_i;

   always @(posedge aclk_i)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("run stopped at cycle %0d before the tests completed", cycles);
         $display("test failed");
         $finish;
      end
   end

   // Galois LFSR that is stepped once for every bit handed out
   function automatic logic take_bit();
      if (lfsr_state[0])
         lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      else
         lfsr_state = lfsr_state >> 1;
      return lfsr_state[0];
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      repeat (n)
         v = {v[30:0], take_bit()};
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      checks++;
      if (got !== want)
      begin
         errors++;
         test_errors++;
         $display("[FAIL] %0t %s expected %h got %h", $time, name, want, got);
      end
   endtask

   task automatic take_expected(input string name, input logic [31:0] got);
      if (exp_q.size() == 0)
      begin
         errors++;
         test_errors++;
         $display("%0t %s delivered an address that was never accepted", $time, name);
      end
      else
         check_value(name, got, exp_q.pop_front());
   endtask

   task automatic end_test(input string name);
      $display("%s done with %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   task automatic write_csr(input logic [3:0] idx, input logic [31:0] data);
      @(negedge aclk_i);
      csr_wr_valid_i = 1'b1;
      csr_wr_addr_i  = idx;
      csr_wr_data_i  = data;
      do
         @(posedge aclk_i);
      while (!csr_wr_ready_o);
      @(negedge aclk_i);
      csr_wr_valid_i = 1'b0;
   endtask

   // returns the response data and the time of the accepting edge
   task automatic read_csr(input logic [3:0] idx, output logic [31:0] data, output time at);
      @(negedge aclk_i);
      csr_rd_valid_i = 1'b1;
      csr_rd_addr_i  = idx;
      do
         @(posedge aclk_i);
      while (!csr_rd_ready_o);
      at = $time;
      do
      begin
         @(negedge aclk_i);
         csr_rd_valid_i    = 1'b0;
         csr_rdata_ready_i = take_bit();
         @(posedge aclk_i);
      end
      while (!(csr_rdata_valid_o && csr_rdata_ready_i));
      data = csr_rdata_o;
      @(negedge aclk_i);
      csr_rdata_ready_i = 1'b0;
   endtask

   task automatic test_registers();
      logic [31:0] rdata;
      time         at;
      check_value("core_reset_o", {31'b0, core_reset_o}, 32'd1);
      write_csr(csr_ctrl, 32'd1);
      check_value("core_reset_o", {31'b0, core_reset_o}, 32'd0);
      base_model = take_bits(32);
      write_csr(csr_dram_base, base_model);
      write_csr(csr_dram_alloc, 32'd1);
      read_csr(csr_ctrl, rdata, at);
      check_value("csr_rdata_o", rdata, 32'd1);
      read_csr(csr_dram_base, rdata, at);
      check_value("csr_rdata_o", rdata, base_model);
      read_csr(csr_dram_alloc, rdata, at);
      check_value("csr_rdata_o", rdata, 32'd1);
      check_value("dram_alloc_o", {31'b0, dram_alloc_o}, 32'd1);
      read_csr(4'd15, rdata, at);
      check_value("csr_rdata_o", rdata, 32'd0);
   endtask

   task automatic run_window();
      int          sent;
      int          got;
      logic        in_fire;
      logic [31:0] rnd;
      sent    = 0;
      got     = 0;
      in_fire = 1'b0;
      while (got < win_items)
      begin
         @(negedge aclk_i);
         if (in_fire || !win_valid_i)
         begin
            rnd         = take_bits(31);
            win_valid_i = (sent < win_items) && rnd[30];
            win_addr_i  = rnd[29:0];
         end
         core_win_ready_i = take_bit();
         @(posedge aclk_i);
         in_fire = win_valid_i && win_ready_o;
         if (core_win_valid_o && core_win_ready_i)
         begin
            take_expected("core_win_addr_o", core_win_addr_o);
            got++;
         end
         if (in_fire)
         begin
            exp_q.push_back({~win_addr_i[29], 3'b000, win_addr_i[27:0]});
            sent++;
         end
      end
      @(negedge aclk_i);
      win_valid_i      = 1'b0;
      core_win_ready_i = 1'b0;
   endtask

   task automatic run_dram();
      int          sent;
      int          got;
      logic        in_fire;
      logic [31:0] rnd;
      logic [31:0] offset;
      sent    = 0;
      got     = 0;
      in_fire = 1'b0;
      while (got < dram_items)
      begin
         @(negedge aclk_i);
         if (in_fire || !dram_req_valid_i)
         begin
            rnd              = take_bits(32);
            dram_req_valid_i = (sent < dram_items) && rnd[31];
            // the first half stays low in DRAM and the rest spreads over all regions
            if (sent < dram_items / 2)
               dram_req_addr_i = {4'b1000, rnd[27:0]};
            else
               dram_req_addr_i = {1'b1, rnd[30:0]};
         end
         mem_ready_i = take_bit();
         @(posedge aclk_i);
         in_fire = dram_req_valid_i && dram_req_ready_o;
         check_value("dram_range_err_o", {31'b0, dram_range_err_o}, {31'b0, range_model});
         if (mem_valid_o && mem_ready_i)
         begin
            take_expected("mem_addr_o", mem_addr_o);
            got++;
         end
         if (in_fire)
         begin
            offset = dram_req_addr_i ^ dram_core_base;
            exp_q.push_back(offset + base_model);
            hits_model[dram_req_addr_i[region_msb:region_lsb]] = 1'b1;
            if (offset >= dram_upper_limit)
               range_model = 1'b1;
            sent++;
         end
      end
      @(negedge aclk_i);
      dram_req_valid_i = 1'b0;
      mem_ready_i      = 1'b0;
   endtask

   task automatic compare_profiler();
      logic [3:0]  idx;
      logic [31:0] rdata;
      time         at;
      int          i;
      idx = csr_prof0;
      for (i = 0; i < 4; i++)
      begin
         read_csr(idx, rdata, at);
         check_value("csr_rdata_o", rdata, hits_model[i*reg_width +: reg_width]);
         idx = idx + 4'd1;
      end
      check_value("dram_range_err_o", {31'b0, dram_range_err_o}, {31'b0, range_model});
   endtask

   task automatic test_profiler();
      compare_profiler();
      // a core restart clears what the profiler has collected
      write_csr(csr_ctrl, 32'd0);
      write_csr(csr_ctrl, 32'd1);
      hits_model  = '0;
      range_model = 1'b0;
      compare_profiler();
   endtask

   task automatic test_counters();
      int          retired;
      logic [31:0] first;
      logic [31:0] second;
      time         t0;
      time         t1;
      retired = 0;
      repeat (retire_cycles)
      begin
         @(negedge aclk_i);
         retire_i = take_bit();
         if (retire_i)
            retired++;
      end
      @(negedge aclk_i);
      retire_i = 1'b0;
      read_csr(csr_minstret_lo, first, t0);
      check_value("csr_rdata_o", first, retired);
      read_csr(csr_minstret_hi, first, t0);
      check_value("csr_rdata_o", first, 32'd0);
      read_csr(csr_mcycle_lo, first, t0);
      read_csr(csr_mcycle_lo, second, t1);
      check_value("csr_rdata_o", second - first, 32'((t1 - t0) / clk_period));
   endtask

   initial
   begin
      rst_n_i           = 1'b0;
      csr_wr_valid_i    = 1'b0;
      csr_wr_addr_i     = '0;
      csr_wr_data_i     = '0;
      csr_rd_valid_i    = 1'b0;
      csr_rd_addr_i     = '0;
      csr_rdata_ready_i = 1'b0;
      win_valid_i       = 1'b0;
      win_addr_i        = '0;
      core_win_ready_i  = 1'b0;
      dram_req_valid_i  = 1'b0;
      dram_req_addr_i   = '0;
      mem_ready_i       = 1'b0;
      retire_i          = 1'b0;
      hits_model        = '0;
      range_model       = 1'b0;
      base_model        = '0;
      repeat (3)
         @(negedge aclk_i);
      rst_n_i = 1'b1;
      @(negedge aclk_i);
      test_registers();
      end_test("registers");
      run_window();
      end_test("window translation");
      run_dram();
      end_test("dram rebase");
      test_profiler();
      end_test("profiler");
      test_counters();
      end_test("counters");
      $display("checks %0d, errors %0d, assertion errors %0d", checks, errors,
               dut.checks.assert_errors);
      if (errors == 0 && dut.checks.assert_errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* test/zynq_host_shell_assert.sv */
`default_nettype none

module zynq_host_shell_assert
   import zynq_shell_pkg::*;
(
   input logic                       aclk_i,
   input logic                       rst_n_i,
   input logic                       core_reset_i,
   input logic                       win_valid_i,
   input logic                       win_ready_i,
   input logic [host_addr_width-1:0] win_addr_i,
   input logic                       cw_valid_i,
   input logic                       cw_ready_i,
   input logic [core_addr_width-1:0] cw_addr_i,
   input logic                       rq_valid_i,
   input logic                       rq_ready_i,
   input logic [core_addr_width-1:0] rq_addr_i,
   input logic [reg_width-1:0]       dram_base_i,
   input logic                       mem_valid_i,
   input logic                       mem_ready_i,
   input logic [core_addr_width-1:0] mem_addr_i,
   input logic                       rd_valid_i,
   input logic                       rd_ready_i,
   input logic [reg_width-1:0]       rd_data_i,
   input logic                       range_err_i
);

   int assert_errors = 0;

   // while reset is held and at the first edge after it, the shell is idle
   // and the core stays in reset
   reset_state : assert property (@(posedge aclk_i)
      !rst_n_i || $rose(rst_n_i) |-> core_reset_i && !cw_valid_i && !mem_valid_i
         && !rd_valid_i && !range_err_i)
   else
   begin
      assert_errors++;
      $error("shell not idle with the core in reset after reset");
   end

   win_hold : assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      cw_valid_i && !cw_ready_i |=> cw_valid_i && $stable(cw_addr_i))
   else
   begin
      assert_errors++;
      $error("core window output changed while stalled");
   end

   // bit 29 picks between core DRAM and the core local space
   win_xlate : assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      win_valid_i && win_ready_i |=> cw_valid_i
         && cw_addr_i == {~$past(win_addr_i[29]), 3'b000, $past(win_addr_i[27:0])})
   else
   begin
      assert_errors++;
      $error("core window address does not follow the translation rule");
   end

   mem_hold : assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
   else
   begin
      assert_errors++;
      $error("memory request changed while stalled");
   end

   mem_rebase : assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rq_valid_i && rq_ready_i |=> mem_valid_i
         && mem_addr_i == (($past(rq_addr_i) ^ dram_core_base) + $past(dram_base_i)))
   else
   begin
      assert_errors++;
      $error("memory address does not follow the rebase rule");
   end

   rdata_hold : assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_data_i))
   else
   begin
      assert_errors++;
      $error("read response changed while stalled");
   end

endmodule

bind zynq_host_shell zynq_host_shell_assert checks (
   .aclk_i       (aclk_i),
   .rst_n_i      (rst_n_i),
   .core_reset_i (core_reset_o),
   .win_valid_i  (win_valid_i),
   .win_ready_i  (win_ready_o),
   .win_addr_i   (win_addr_i),
   .cw_valid_i   (core_win_valid_o),
   .cw_ready_i   (core_win_ready_i),
   .cw_addr_i    (core_win_addr_o),
   .rq_valid_i   (dram_req_valid_i),
   .rq_ready_i   (dram_req_ready_o),
   .rq_addr_i    (dram_req_addr_i),
   .dram_base_i  (dram_base),
   .mem_valid_i  (mem_valid_o),
   .mem_ready_i  (mem_ready_i),
   .mem_addr_i   (mem_addr_o),
   .rd_valid_i   (csr_rdata_valid_o),
   .rd_ready_i   (csr_rdata_ready_i),
   .rd_data_i    (csr_rdata_o),
   .range_err_i  (dram_range_err_o)
);

`default_nettype wire

/* hw/zynq_host_shell.sv */
`default_nettype none

module zynq_host_shell
   import zynq_shell_pkg::*;
(
   input  logic                       aclk_i,
   input  logic                       rst_n_i,

   // host register port
   input  logic                       csr_wr_valid_i,
   output logic                       csr_wr_ready_o,
   input  logic [csr_addr_width-1:0]  csr_wr_addr_i,
   input  logic [reg_width-1:0]       csr_wr_data_i,
   input  logic                       csr_rd_valid_i,
   output logic                       csr_rd_ready_o,
   input  logic [csr_addr_width-1:0]  csr_rd_addr_i,
   output logic                       csr_rdata_valid_o,
   input  logic                       csr_rdata_ready_i,
   output logic [reg_width-1:0]       csr_rdata_o,

   // host window into the core address space
   input  logic                       win_valid_i,
   output logic                       win_ready_o,
   input  logic [host_addr_width-1:0] win_addr_i,
   output logic                       core_win_valid_o,
   input  logic                       core_win_ready_i,
   output logic [core_addr_width-1:0] core_win_addr_o,

   // core DRAM requests out to the PS memory
   input  logic                       dram_req_valid_i,
   output logic                       dram_req_ready_o,
   input  logic [core_addr_width-1:0] dram_req_addr_i,
   output logic                       mem_valid_o,
   input  logic                       mem_ready_i,
   output logic [core_addr_width-1:0] mem_addr_o,

   input  logic                       retire_i,
   output logic                       dram_range_err_o,
   output logic                       core_reset_o,
   output logic                       dram_alloc_o
);

   logic                       core_run;
   logic [reg_width-1:0]       dram_base;
   logic [region_count-1:0]    region_hits;
   logic [cnt_width-1:0]       mcycle;
   logic [cnt_width-1:0]       minstret;

   // the host can restart the core through bit 0 of the control word
   // without a full reset of the shell
   assign core_reset_o = ~rst_n_i | ~core_run;

   host_csr host_regs (
      .aclk_i            (aclk_i),
      .rst_n_i           (rst_n_i),
      .csr_wr_valid_i    (csr_wr_valid_i),
      .csr_wr_ready_o    (csr_wr_ready_o),
      .csr_wr_addr_i     (csr_wr_addr_i),
      .csr_wr_data_i     (csr_wr_data_i),
      .csr_rd_valid_i    (csr_rd_valid_i),
      .csr_rd_ready_o    (csr_rd_ready_o),
      .csr_rd_addr_i     (csr_rd_addr_i),
      .csr_rdata_valid_o (csr_rdata_valid_o),
      .csr_rdata_ready_i (csr_rdata_ready_i),
      .csr_rdata_o       (csr_rdata_o),
      .region_hits_i     (region_hits),
      .mcycle_i          (mcycle),
      .minstret_i        (minstret),
      .core_run_o        (core_run),
      .dram_base_o       (dram_base),
      .dram_alloc_o      (dram_alloc_o)
   );

   host_window_xlate win_stage (
      .aclk_i           (aclk_i),
      .rst_n_i          (rst_n_i),
      .win_valid_i      (win_valid_i),
      .win_ready_o      (win_ready_o),
      .win_addr_i       (win_addr_i),
      .core_win_valid_o (core_win_valid_o),
      .core_win_ready_i (core_win_ready_i),
      .core_win_addr_o  (core_win_addr_o)
   );

   dram_rebase dram_stage (
      .aclk_i           (aclk_i),
      .rst_n_i          (rst_n_i),
      .core_reset_i     (core_reset_o),
      .dram_base_i      (dram_base),
      .dram_req_valid_i (dram_req_valid_i),
      .dram_req_ready_o (dram_req_ready_o),
      .dram_req_addr_i  (dram_req_addr_i),
      .mem_valid_o      (mem_valid_o),
      .mem_ready_i      (mem_ready_i),
      .mem_addr_o       (mem_addr_o),
      .region_hits_o    (region_hits),
      .dram_range_err_o (dram_range_err_o)
   );

   perf_counters perf (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .core_reset_i (core_reset_o),
      .retire_i     (retire_i),
      .mcycle_o     (mcycle),
      .minstret_o   (minstret)
   );

endmodule

`default_nettype wire

/* hw/perf_counters.sv */
`default_nettype none

module perf_counters
   import zynq_shell_pkg::*;
(
   input  logic                 aclk_i,
   input  logic                 rst_n_i,
   input  logic                 core_reset_i,
   input  logic                 retire_i,
   output logic [cnt_width-1:0] mcycle_o,
   output logic [cnt_width-1:0] minstret_o
);

   logic [cnt_width-1:0] mcycle_q;
   logic [cnt_width-1:0] minstret_q;

   // both counters sit at zero for as long as the core is held in reset
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         mcycle_q   <= '0;
         minstret_q <= '0;
      end
      else if (core_reset_i)
      begin
         mcycle_q   <= '0;
         minstret_q <= '0;
      end
      else
      begin
         mcycle_q <= mcycle_q + 1'b1;
         if (retire_i)
            minstret_q <= minstret_q + 1'b1;
      end
   end

   assign mcycle_o   = mcycle_q;
   assign minstret_o = minstret_q;

endmodule

`default_nettype wire

/* hw/dram_rebase.sv */
`default_nettype none

module dram_rebase
   import zynq_shell_pkg::*;
(
   input  logic                       aclk_i,
   input  logic                       rst_n_i,
   input  logic                       core_reset_i,
   input  logic [core_addr_width-1:0] dram_base_i,

   input  logic                       dram_req_valid_i,
   output logic                       dram_req_ready_o,
   input  logic [core_addr_width-1:0] dram_req_addr_i,

   output logic                       mem_valid_o,
   input  logic                       mem_ready_i,
   output logic [core_addr_width-1:0] mem_addr_o,

   output logic [region_count-1:0]    region_hits_o,
   output logic                       dram_range_err_o
);

   logic                             req_fire;
   logic [core_addr_width-1:0]       offset;
   logic [core_addr_width-1:0]       rebased;
   logic [region_msb-region_lsb:0]   region_idx;
   logic                             full_q;
   logic [core_addr_width-1:0]       addr_q;
   logic [region_count-1:0]          hits_q;
   logic                             range_err_q;

   // core DRAM is based at 0x8000_0000, so the xor strips the base and the
   // sum moves the request into the buffer allocated by the PS
   assign offset     = dram_req_addr_i ^ dram_core_base;
   assign rebased    = offset + dram_base_i;
   assign region_idx = dram_req_addr_i[region_msb:region_lsb];

   assign dram_req_ready_o = ~full_q | mem_ready_i;
   assign req_fire         = dram_req_valid_i & dram_req_ready_o;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         full_q <= 1'b0;
      else if (req_fire)
         full_q <= 1'b1;
      else if (mem_ready_i)
         full_q <= 1'b0;
   end

   always_ff @(posedge aclk_i)
   begin
      if (req_fire)
         addr_q <= rebased;
   end

   // the profiler keeps one bit per region to show how much DRAM a program touches
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         hits_q      <= '0;
         range_err_q <= 1'b0;
      end
      else if (core_reset_i)
      begin
         hits_q      <= '0;
         range_err_q <= 1'b0;
      end
      else if (req_fire)
      begin
         hits_q[region_idx] <= 1'b1;
         if (offset >= dram_upper_limit)
            range_err_q <= 1'b1;
      end
   end

   assign mem_valid_o      = full_q;
   assign mem_addr_o       = addr_q;
   assign region_hits_o    = hits_q;
   assign dram_range_err_o = range_err_q;

endmodule

`default_nettype wire

/* hw/host_window_xlate.sv */
`default_nettype none

module host_window_xlate
   import zynq_shell_pkg::*;
(
   input  logic                       aclk_i,
   input  logic                       rst_n_i,

   input  logic                       win_valid_i,
   output logic                       win_ready_o,
   input  logic [host_addr_width-1:0] win_addr_i,

   output logic                       core_win_valid_o,
   input  logic                       core_win_ready_i,
   output logic [core_addr_width-1:0] core_win_addr_o
);

   logic                       win_fire;
   logic [core_addr_width-1:0] xlate_addr;
   logic                       full_q;
   logic [core_addr_width-1:0] addr_q;

   // window 0x0000_0000 maps onto core DRAM at 0x8000_0000 and window
   // 0x2000_0000 onto the core local space at 0x0000_0000
   assign xlate_addr = {~win_addr_i[host_addr_width-1], 3'b000, win_addr_i[27:0]};

   // a new address may enter in the same cycle the held one leaves
   assign win_ready_o = ~full_q | core_win_ready_i;
   assign win_fire    = win_valid_i & win_ready_o;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         full_q <= 1'b0;
      else if (win_fire)
         full_q <= 1'b1;
      else if (core_win_ready_i)
         full_q <= 1'b0;
   end

   always_ff @(posedge aclk_i)
   begin
      if (win_fire)
         addr_q <= xlate_addr;
   end

   assign core_win_valid_o = full_q;
   assign core_win_addr_o  = addr_q;

endmodule

`default_nettype wire

/* hw/host_csr.sv */
`default_nettype none

module host_csr
   import zynq_shell_pkg::*;
(
   input  logic                      aclk_i,
   input  logic                      rst_n_i,

   input  logic                      csr_wr_valid_i,
   output logic                      csr_wr_ready_o,
   input  logic [csr_addr_width-1:0] csr_wr_addr_i,
   input  logic [reg_width-1:0]      csr_wr_data_i,

   input  logic                      csr_rd_valid_i,
   output logic                      csr_rd_ready_o,
   input  logic [csr_addr_width-1:0] csr_rd_addr_i,

   output logic                      csr_rdata_valid_o,
   input  logic                      csr_rdata_ready_i,
   output logic [reg_width-1:0]      csr_rdata_o,

   input  logic [region_count-1:0]   region_hits_i,
   input  logic [cnt_width-1:0]      mcycle_i,
   input  logic [cnt_width-1:0]      minstret_i,

   output logic                      core_run_o,
   output logic [reg_width-1:0]      dram_base_o,
   output logic                      dram_alloc_o
);

   csr_addr_e            wr_sel;
   csr_addr_e            rd_sel;
   logic                 port_up_q;
   logic                 wr_fire;
   logic                 rd_fire;
   logic [reg_width-1:0] ctrl_q;
   logic [reg_width-1:0] alloc_q;
   logic [reg_width-1:0] base_q;
   logic [reg_width-1:0] rd_mux;
   logic                 rvalid_q;
   logic [reg_width-1:0] rdata_q;

   assign wr_sel = csr_addr_e'(csr_wr_addr_i);
   assign rd_sel = csr_addr_e'(csr_rd_addr_i);

   // the port comes up one edge after reset is released
   assign csr_wr_ready_o = port_up_q;
   assign csr_rd_ready_o = port_up_q & ~rvalid_q;

   assign wr_fire = csr_wr_valid_i & csr_wr_ready_o;
   assign rd_fire = csr_rd_valid_i & csr_rd_ready_o;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         port_up_q <= 1'b0;
         ctrl_q    <= '0;
         alloc_q   <= '0;
         base_q    <= '0;
      end
      else
      begin
         port_up_q <= 1'b1;
         if (wr_fire)
         begin
            // only the first three words take writes
            case (wr_sel)
               csr_ctrl:       ctrl_q  <= csr_wr_data_i;
               csr_dram_alloc: alloc_q <= csr_wr_data_i;
               csr_dram_base:  base_q  <= csr_wr_data_i;
               default:        ;
            endcase
         end
      end
   end

   always_comb
   begin
      case (rd_sel)
         csr_ctrl:        rd_mux = ctrl_q;
         csr_dram_alloc:  rd_mux = alloc_q;
         csr_dram_base:   rd_mux = base_q;
         csr_prof0:       rd_mux = region_hits_i[0*reg_width +: reg_width];
         csr_prof1:       rd_mux = region_hits_i[1*reg_width +: reg_width];
         csr_prof2:       rd_mux = region_hits_i[2*reg_width +: reg_width];
         csr_prof3:       rd_mux = region_hits_i[3*reg_width +: reg_width];
         csr_mcycle_lo:   rd_mux = mcycle_i[reg_width-1:0];
         csr_mcycle_hi:   rd_mux = mcycle_i[cnt_width-1:reg_width];
         csr_minstret_lo: rd_mux = minstret_i[reg_width-1:0];
         csr_minstret_hi: rd_mux = minstret_i[cnt_width-1:reg_width];
         default:         rd_mux = '0;
      endcase
   end

   // one response slot that is freed when the host takes it
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         rvalid_q <= 1'b0;
      else if (rd_fire)
         rvalid_q <= 1'b1;
      else if (csr_rdata_ready_i)
         rvalid_q <= 1'b0;
   end

   always_ff @(posedge aclk_i)
   begin
      if (rd_fire)
         rdata_q <= rd_mux;
   end

   assign csr_rdata_valid_o = rvalid_q;
   assign csr_rdata_o       = rdata_q;

   assign core_run_o   = ctrl_q[0];
   assign dram_alloc_o = alloc_q[0];
   assign dram_base_o  = base_q;

endmodule

`default_nettype wire

/* hw/zynq_shell_pkg.sv */
`default_nettype none

package zynq_shell_pkg;

   // host register word and the index that selects one
   localparam int reg_width      = 32;
   localparam int csr_addr_width = 4;

   // the host window port drops the top two bits of the PS physical address
   localparam int host_addr_width = 30;

   // core physical address and counter widths
   localparam int core_addr_width = 32;
   localparam int cnt_width       = 64;

   // each profiler bit covers one 8 MiB slice of the core DRAM space
   localparam int region_count = 128;
   localparam int region_msb   = 29;
   localparam int region_lsb   = 23;

   // core DRAM starts here, and it is removed with an xor before rebasing
   localparam logic [core_addr_width-1:0] dram_core_base = 32'h8000_0000;

   // offsets at or above this point run past what the PS side hands out
   localparam logic [core_addr_width-1:0] dram_upper_limit = 32'h0F10_0000;

   // register word indices of the host port
   typedef enum logic [csr_addr_width-1:0] {
      csr_ctrl        = 4'd0,
      csr_dram_alloc  = 4'd1,
      csr_dram_base   = 4'd2,
      csr_prof0       = 4'd3,
      csr_prof1       = 4'd4,
      csr_prof2       = 4'd5,
      csr_prof3       = 4'd6,
      csr_mcycle_lo   = 4'd7,
      csr_mcycle_hi   = 4'd8,
      csr_minstret_lo = 4'd9,
      csr_minstret_hi = 4'd10
   } csr_addr_e;

endpackage

`default_nettype wire
